//--- common/rtos_timer_macros.svh
// widths, register byte offsets and reset values of the RTOS timer, included by its RTL files.
`ifndef RTOS_TIMER_MACROS_SVH
`define RTOS_TIMER_MACROS_SVH

`define RT_SYSTIM_WIDTH     32      // system time, alarm compare and alarm period.
`define RT_PRESCL_WIDTH     16
`define RT_APB_ADDR_WIDTH   8
`define RT_APB_DATA_WIDTH   32

// register byte offsets on the APB bus.
`define RT_ADDR_CTRL         8'h00
`define RT_ADDR_PRESCALE     8'h04
`define RT_ADDR_SYSTIM       8'h08
`define RT_ADDR_ALARM_CMP    8'h0C
`define RT_ADDR_ALARM_PERIOD 8'h10
`define RT_ADDR_STATUS       8'h14

// bit positions in CTRL and STATUS.
`define RT_CTRL_TIMER_EN     0
`define RT_CTRL_ALARM_EN     1
`define RT_CTRL_PERIODIC     2
`define RT_CTRL_IRQ_EN       3
`define RT_STATUS_PENDING    0

`define RT_INIT_PRESCL       0      // a prescale of zero gives one tick per enabled clock.
`define RT_INIT_CTRL         4'h0

`endif

//--- common/rtos_timer_pkg.sv
// types shared by the RTOS timer blocks, imported by wildcard in each module header.
`default_nettype none

`include "rtos_timer_macros.svh"

package rtos_timer_pkg;

    // system time, alarm compare and alarm period all share this width.
    typedef logic [`RT_SYSTIM_WIDTH-1:0] systim_t;

    typedef logic [`RT_PRESCL_WIDTH-1:0] prescl_t;

    typedef logic [`RT_APB_DATA_WIDTH-1:0] apb_data_t;

    // register word offsets, which are the byte addresses shifted right by two.
    typedef enum logic [5:0] {
        CTRL         = 6'(`RT_ADDR_CTRL >> 2),
        PRESCALE     = 6'(`RT_ADDR_PRESCALE >> 2),
        SYSTIM       = 6'(`RT_ADDR_SYSTIM >> 2),     // read gives live time, write loads it.
        ALARM_CMP    = 6'(`RT_ADDR_ALARM_CMP >> 2),
        ALARM_PERIOD = 6'(`RT_ADDR_ALARM_PERIOD >> 2),
        STATUS       = 6'(`RT_ADDR_STATUS >> 2)      // write one to clear the pending bit.
    } rt_reg_e;

    // the alarm waits in ARMED for a match and spends exactly one cycle in FIRE.
    typedef enum logic [1:0] {
        IDLE  = 2'd0,
        ARMED = 2'd1,
        FIRE  = 2'd2
    } alarm_state_e;

endpackage

`default_nettype wire

//--- timer/sys_timer.sv
// prescaler and loadable system-time counter, giving the time tick and the current time.
`timescale 1ns/10ps
`default_nettype none

`include "rtos_timer_macros.svh"

module sys_timer import rtos_timer_pkg::*; (
    input  wire          clk,
    input  wire          reset,
    input  wire          timer_enable,
    input  wire prescl_t prescale_value,
    input  wire          set_time_valid,
    input  wire systim_t set_time_value,
    output logic         time_tick,
    output systim_t      systim
);

    prescl_t prescaler_count;
    prescl_t prescaler_count_next;

    // the count runs down to zero and then picks up the current prescale value.
    // a new prescale value therefore only matters at the next reload.
    always_comb begin
        if (prescaler_count != '0) begin
            prescaler_count_next = prescaler_count - 1'b1;
        end else begin
            prescaler_count_next = prescale_value;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            prescaler_count <= prescl_t'(`RT_INIT_PRESCL);
            time_tick       <= 1'b0;           // the timer starts disabled, so no tick.
        end else if (timer_enable) begin
            prescaler_count <= prescaler_count_next;
            time_tick       <= (prescaler_count_next == '0);
        end else begin
            // the count holds while disabled but the tick must not stick high.
            time_tick <= 1'b0;
        end
    end

    // a load from software wins over the tick and leaves the prescaler alone.
    always_ff @(posedge clk) begin
        if (reset) begin
            systim <= '0;
        end else if (set_time_valid) begin
            systim <= set_time_value;
        end else if (time_tick) begin
            systim <= systim + 1'b1;          // one step per tick, not per clock.
        end
    end

endmodule

`default_nettype wire

//--- timer/alarm_ctrl.sv
// alarm state machine that compares system time with the compare value, one-shot or periodic.
`timescale 1ns/10ps
`default_nettype none

`include "rtos_timer_macros.svh"

module alarm_ctrl import rtos_timer_pkg::*; (
    input  wire          clk,
    input  wire          reset,
    input  wire          alarm_enable,
    input  wire          alarm_periodic,
    input  wire systim_t alarm_cmp,
    input  wire systim_t alarm_period,
    input  wire          cmp_write,
    input  wire systim_t systim,
    output logic         fire_pulse,
    output logic         cmp_reload,
    output systim_t      next_cmp
);

    alarm_state_e state_q;
    alarm_state_e state_d;
    logic         enable_q;
    logic         enable_rise;
    logic         time_match;

    assign enable_rise = alarm_enable & ~enable_q;
    assign time_match  = (systim == alarm_cmp);

    // the next periodic compare value, stored by the register block on cmp_reload.
    assign next_cmp = alarm_cmp + alarm_period;

    always_comb begin
        state_d = state_q;
        if (!alarm_enable) begin
            state_d = IDLE;                   // disabling always drops the alarm.
        end else if (cmp_write || enable_rise) begin
            state_d = ARMED;
        end else begin
            case (state_q)
                ARMED: begin
                    if (time_match) begin
                        state_d = FIRE;
                    end
                end
                FIRE: begin
                    // periodic mode stays armed against the reloaded compare value.
                    state_d = alarm_periodic ? ARMED : IDLE;
                end
                default: begin
                    state_d = IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q  <= IDLE;
            enable_q <= 1'b0;
        end else begin
            state_q  <= state_d;
            enable_q <= alarm_enable;
        end
    end

    assign fire_pulse = (state_q == FIRE);  // one cycle, it sets the pending bit.

    // a compare write from software in the same cycle takes priority over the reload.
    assign cmp_reload = (state_q == FIRE) && alarm_periodic && alarm_enable && !cmp_write;

endmodule

`default_nettype wire

//--- src/apb_timer_regs.sv
// APB register block of the RTOS timer, holding control, prescale, alarm and status registers.
`timescale 1ns/10ps
`default_nettype none

`include "rtos_timer_macros.svh"

module apb_timer_regs import rtos_timer_pkg::*; (
    input  wire                           clk,
    input  wire                           reset,
    input  wire                           psel,
    input  wire                           penable,
    input  wire                           pwrite,
    input  wire  [`RT_APB_ADDR_WIDTH-1:0] paddr,
    input  wire  apb_data_t               pwdata,
    output apb_data_t                     prdata,
    output logic                          pready,
    output logic                          pslverr,
    input  wire  systim_t                 systim,
    input  wire                           fire_pulse,
    input  wire                           cmp_reload,
    input  wire  systim_t                 next_cmp,
    output logic                          timer_enable,
    output prescl_t                       prescale_value,
    output logic                          set_time_valid,
    output systim_t                       set_time_value,
    output logic                          alarm_enable,
    output logic                          alarm_periodic,
    output systim_t                       alarm_cmp,
    output systim_t                       alarm_period,
    output logic                          cmp_write,
    output logic                          irq_enable,
    output logic                          pending
);

    rt_reg_e   reg_sel;
    logic      addr_valid;
    logic      wr_en;
    apb_data_t rdata;
    logic [3:0] ctrl_q;

    // the word offset ignores the two low address bits.
    assign reg_sel = rt_reg_e'(paddr[`RT_APB_ADDR_WIDTH-1:2]);

    // no wait states, every access finishes in its first access cycle.
    assign pready = 1'b1;
    assign wr_en  = psel & penable & pwrite & addr_valid;

    // read multiplexer and address decode. An unknown offset reads as zero.
    always_comb begin
        addr_valid = 1'b1;
        rdata      = '0;
        case (reg_sel)
            CTRL:         rdata = apb_data_t'(ctrl_q);
            PRESCALE:     rdata = apb_data_t'(prescale_value);
            SYSTIM:       rdata = apb_data_t'(systim);   // live time, not a snapshot.
            ALARM_CMP:    rdata = apb_data_t'(alarm_cmp);
            ALARM_PERIOD: rdata = apb_data_t'(alarm_period);
            STATUS:       rdata = apb_data_t'(pending);
            default:      addr_valid = 1'b0;
        endcase
    end

    assign prdata  = psel ? rdata : '0;
    assign pslverr = psel & penable & ~addr_valid;

    // these pulses last for the access cycle, so the loads land on the edge that ends it.
    assign set_time_valid = wr_en && (reg_sel == SYSTIM);
    assign set_time_value = systim_t'(pwdata);
    assign cmp_write      = wr_en && (reg_sel == ALARM_CMP);

    always_ff @(posedge clk) begin
        if (reset) begin
            ctrl_q         <= `RT_INIT_CTRL;
            prescale_value <= prescl_t'(`RT_INIT_PRESCL);
            alarm_period   <= '0;
        end else if (wr_en) begin
            case (reg_sel)
                CTRL:         ctrl_q         <= pwdata[3:0];
                PRESCALE:     prescale_value <= prescl_t'(pwdata);
                ALARM_PERIOD: alarm_period   <= systim_t'(pwdata);
                default:      ctrl_q         <= ctrl_q;
            endcase
        end
    end

    // software writes and periodic reloads share the compare register.
    always_ff @(posedge clk) begin
        if (reset) begin
            alarm_cmp <= '0;
        end else if (cmp_write) begin
            alarm_cmp <= systim_t'(pwdata);
        end else if (cmp_reload) begin
            alarm_cmp <= next_cmp;
        end
    end

    // a fire in the same cycle as a clear keeps the bit set, so no alarm is lost.
    always_ff @(posedge clk) begin
        if (reset) begin
            pending <= 1'b0;
        end else if (fire_pulse) begin
            pending <= 1'b1;
        end else if (wr_en && (reg_sel == STATUS) && pwdata[`RT_STATUS_PENDING]) begin
            pending <= 1'b0;
        end
    end

    assign timer_enable   = ctrl_q[`RT_CTRL_TIMER_EN];
    assign alarm_enable   = ctrl_q[`RT_CTRL_ALARM_EN];
    assign alarm_periodic = ctrl_q[`RT_CTRL_PERIODIC];
    assign irq_enable     = ctrl_q[`RT_CTRL_IRQ_EN];

endmodule

`default_nettype wire

//--- src/rtos_timer_top.sv
// top level of the RTOS system-time unit, an APB slave with one interrupt output.
`timescale 1ns/10ps
`default_nettype none

`include "rtos_timer_macros.svh"

module rtos_timer_top import rtos_timer_pkg::*; (
    input  wire                           clk,
    input  wire                           reset,
    input  wire                           psel,
    input  wire                           penable,
    input  wire                           pwrite,
    input  wire  [`RT_APB_ADDR_WIDTH-1:0] paddr,
    input  wire  apb_data_t               pwdata,
    output apb_data_t                     prdata,
    output logic                          pready,
    output logic                          pslverr,
    output logic                          irq
);

    logic    timer_enable;
    prescl_t prescale_value;
    logic    set_time_valid;
    systim_t set_time_value;
    systim_t systim;
    logic    alarm_enable;
    logic    alarm_periodic;
    systim_t alarm_cmp;
    systim_t alarm_period;
    logic    cmp_write;
    logic    fire_pulse;
    logic    cmp_reload;
    systim_t next_cmp;
    logic    irq_enable;
    logic    pending;

    apb_timer_regs u_regs (
        .clk            (clk),
        .reset          (reset),
        .psel           (psel),
        .penable        (penable),
        .pwrite         (pwrite),
        .paddr          (paddr),
        .pwdata         (pwdata),
        .prdata         (prdata),
        .pready         (pready),
        .pslverr        (pslverr),
        .systim         (systim),
        .fire_pulse     (fire_pulse),
        .cmp_reload     (cmp_reload),
        .next_cmp       (next_cmp),
        .timer_enable   (timer_enable),
        .prescale_value (prescale_value),
        .set_time_valid (set_time_valid),
        .set_time_value (set_time_value),
        .alarm_enable   (alarm_enable),
        .alarm_periodic (alarm_periodic),
        .alarm_cmp      (alarm_cmp),
        .alarm_period   (alarm_period),
        .cmp_write      (cmp_write),
        .irq_enable     (irq_enable),
        .pending        (pending)
    );

    sys_timer u_timer (
        .clk            (clk),
        .reset          (reset),
        .timer_enable   (timer_enable),
        .prescale_value (prescale_value),
        .set_time_valid (set_time_valid),
        .set_time_value (set_time_value),
        .time_tick      (),
        .systim         (systim)
    );

    alarm_ctrl u_alarm (
        .clk            (clk),
        .reset          (reset),
        .alarm_enable   (alarm_enable),
        .alarm_periodic (alarm_periodic),
        .alarm_cmp      (alarm_cmp),
        .alarm_period   (alarm_period),
        .cmp_write      (cmp_write),
        .systim         (systim),
        .fire_pulse     (fire_pulse),
        .cmp_reload     (cmp_reload),
        .next_cmp       (next_cmp)
    );

    // the interrupt follows pending and the enable bit one cycle later.
    always_ff @(posedge clk) begin
        if (reset) begin
            irq <= 1'b0;
        end else begin
            irq <= pending & irq_enable;
        end
    end

endmodule

`default_nettype wire

//--- tb/tb_rtos_timer.sv
// self-checking testbench for the RTOS timer; drives APB transfers and checks them with assertions.
`timescale 1ns/10ps
`default_nettype none

`include "rtos_timer_macros.svh"

module tb_rtos_timer;

    localparam int CYCLE_LIMIT = 20000;   // all test waits together, with a wide margin.
    localparam int TICK_CYCLES = 200;
    localparam int IRQ_WAIT    = 400;

    localparam logic [31:0] CTRL_TIMER    = 32'h1 << `RT_CTRL_TIMER_EN;
    localparam logic [31:0] CTRL_ALARM    = 32'h1 << `RT_CTRL_ALARM_EN;
    localparam logic [31:0] CTRL_PERIODIC = 32'h1 << `RT_CTRL_PERIODIC;
    localparam logic [31:0] CTRL_IRQ      = 32'h1 << `RT_CTRL_IRQ_EN;

    logic                          clk;
    logic                          reset;
    logic                          psel;
    logic                          penable;
    logic                          pwrite;
    logic [`RT_APB_ADDR_WIDTH-1:0] paddr;
    logic [31:0]                   pwdata;
    logic [31:0]                   prdata;
    logic                          pready;
    logic                          pslverr;
    logic                          irq;

    // register model, kept by the APB tasks and by the tests where the hardware moves on.
    logic [3:0]  model_ctrl;
    logic [15:0] model_prescale;
    logic [31:0] model_cmp;
    logic [31:0] model_period;
    logic        model_status;

    logic        read_check;
    logic [31:0] exp_lo;
    logic [31:0] exp_hi;
    int          error_count;
    int          test_errors;               // error count when the current test began.
    int          tests_passed;
    int          tests_failed;
    int          cycle_count;
    integer      seed;

    rtos_timer_top uut (
        .clk     (clk),
        .reset   (reset),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .irq     (irq)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Result: FAILED");
            $finish;
        end
    end

    // six registers sit at word offsets 0 to 5.
    function automatic logic addr_mapped(input logic [7:0] addr);
        return addr[7:2] <= (`RT_ADDR_STATUS >> 2);
    endfunction

    function automatic logic [31:0] model_value(input logic [7:0] addr);
        case (addr)
            `RT_ADDR_CTRL:         return {28'h0, model_ctrl};
            `RT_ADDR_PRESCALE:     return {16'h0, model_prescale};
            `RT_ADDR_ALARM_CMP:    return model_cmp;
            `RT_ADDR_ALARM_PERIOD: return model_period;
            `RT_ADDR_STATUS:       return {31'h0, model_status};
            default:               return 32'h0;
        endcase
    endfunction

    pready_high: assert property (@(posedge clk) pready)
        else begin
            $display("[ERROR] pready = 0x%h, expected 0x1", $sampled(pready));
            error_count++;
        end

    pslverr_match: assert property (@(posedge clk) disable iff (reset)
        pslverr == (psel && penable && !addr_mapped(paddr)))
        else begin
            $display("[ERROR] pslverr = 0x%h, expected 0x%h, paddr 0x%h",
                     $sampled(pslverr),
                     $sampled(psel) && $sampled(penable) && !addr_mapped($sampled(paddr)),
                     $sampled(paddr));
            error_count++;
        end

    prdata_match: assert property (@(posedge clk) disable iff (reset)
        (read_check && psel && penable && !pwrite) |-> (prdata >= exp_lo && prdata <= exp_hi))
        else begin
            $display("[ERROR] prdata = 0x%h, expected 0x%h to 0x%h, paddr 0x%h",
                     $sampled(prdata), exp_lo, exp_hi, $sampled(paddr));
            error_count++;
        end

    // irq is registered, so it may lag a cleared enable bit by one cycle.
    irq_masked: assert property (@(posedge clk) disable iff (reset)
        (!model_ctrl[`RT_CTRL_IRQ_EN] && !$past(model_ctrl[`RT_CTRL_IRQ_EN])) |-> !irq)
        else begin
            $display("[ERROR] irq = 0x%h, expected 0x0", $sampled(irq));
            error_count++;
        end

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
        @(posedge clk);
        #1;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        @(posedge clk);
        #1;
        penable = 1'b1;
        @(posedge clk);                     // the write lands on this edge.
        #1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        case (addr)
            `RT_ADDR_CTRL:         model_ctrl     = data[3:0];
            `RT_ADDR_PRESCALE:     model_prescale = data[15:0];
            `RT_ADDR_ALARM_CMP:    model_cmp      = data;
            `RT_ADDR_ALARM_PERIOD: model_period   = data;
            `RT_ADDR_STATUS: begin
                if (data[`RT_STATUS_PENDING]) begin
                    model_status = 1'b0;
                end
            end
            default: begin
            end
        endcase
    endtask

    task automatic apb_read(input logic [7:0] addr, input logic [31:0] lo,
                            input logic [31:0] hi, output logic [31:0] data);
        @(posedge clk);
        #1;
        psel       = 1'b1;
        penable    = 1'b0;
        pwrite     = 1'b0;
        paddr      = addr;
        exp_lo     = lo;
        exp_hi     = hi;
        read_check = 1'b1;
        @(posedge clk);
        #1;
        penable = 1'b1;
        #2;
        data = prdata;                      // nothing changes again before the closing edge.
        @(posedge clk);
        #1;
        psel       = 1'b0;
        penable    = 1'b0;
        read_check = 1'b0;
    endtask

    task automatic check_register(input logic [7:0] addr);
        logic [31:0] data;
        apb_read(addr, model_value(addr), model_value(addr), data);
    endtask

    // at least one edge passes first, so an irq that is still clearing is not taken as new.
    task automatic wait_for_irq();
        int waited;
        waited = 0;
        do begin
            @(posedge clk);
            #1;
            waited++;
        end while (!irq && waited < IRQ_WAIT);
        if (!irq) begin
            $display("irq did not rise within %0d cycles", IRQ_WAIT);
            error_count++;
        end
    endtask

    // polls STATUS for an alarm that fires while the interrupt is masked.
    task automatic wait_for_pending();
        logic [31:0] data;
        int          polls;
        data  = '0;
        polls = 0;
        while (!data[`RT_STATUS_PENDING] && polls < IRQ_WAIT) begin
            apb_read(`RT_ADDR_STATUS, 32'h0, 32'h1, data);
            polls++;
        end
        if (!data[`RT_STATUS_PENDING]) begin
            $display("pending did not set within %0d status reads", IRQ_WAIT);
            error_count++;
        end
    endtask

    task automatic end_test(input string name);
        if (error_count == test_errors) begin
            tests_passed++;
            $display("test %s: passed", name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, error_count - test_errors);
        end
        test_errors = error_count;
    endtask

    initial begin
        logic [31:0] data;
        logic [31:0] value;
        logic [31:0] base;
        int          presc;
        seed           = 8792;
        clk            = 1'b0;
        reset          = 1'b1;
        psel           = 1'b0;
        penable        = 1'b0;
        pwrite         = 1'b0;
        paddr          = '0;
        pwdata         = '0;
        model_ctrl     = '0;
        model_prescale = '0;
        model_cmp      = '0;
        model_period   = '0;
        model_status   = 1'b0;
        read_check     = 1'b0;
        exp_lo         = '0;
        exp_hi         = '0;
        error_count    = 0;
        test_errors    = 0;
        tests_passed   = 0;
        tests_failed   = 0;
        cycle_count    = 0;
        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;

        assert (irq == 1'b0 && pslverr == 1'b0)
            else begin
                $display("[ERROR] irq = 0x%h, pslverr = 0x%h, expected 0x0", irq, pslverr);
                error_count++;
            end
        apb_read(`RT_ADDR_SYSTIM, 32'h0, 32'h0, data);
        check_register(`RT_ADDR_CTRL);
        check_register(`RT_ADDR_PRESCALE);
        check_register(`RT_ADDR_ALARM_CMP);
        check_register(`RT_ADDR_ALARM_PERIOD);
        check_register(`RT_ADDR_STATUS);
        end_test("reset state");

        presc = $unsigned($random(seed)) % 16;
        apb_write(`RT_ADDR_PRESCALE, presc);
        apb_write(`RT_ADDR_SYSTIM, 32'h0);
        apb_write(`RT_ADDR_CTRL, CTRL_TIMER);
        repeat (TICK_CYCLES - 3) @(posedge clk);   // the disabling write adds three edges.
        apb_write(`RT_ADDR_CTRL, 32'h0);
        value = TICK_CYCLES / (presc + 1);
        apb_read(`RT_ADDR_SYSTIM, value - 1, value + 1, data);
        end_test("tick rate");

        apb_write(`RT_ADDR_CTRL, CTRL_TIMER);
        repeat (4) begin
            presc = $unsigned($random(seed)) % 16;
            value = $unsigned($random(seed)) & 32'h7fff_ffff;   // keeps value + 2 from wrapping.
            apb_write(`RT_ADDR_PRESCALE, presc);
            apb_write(`RT_ADDR_SYSTIM, value);
            apb_read(`RT_ADDR_SYSTIM, value, value + 2, data);  // two ticks fit before the read.
        end
        end_test("time load");

        apb_write(`RT_ADDR_PRESCALE, 32'd7);
        apb_write(`RT_ADDR_CTRL, CTRL_TIMER | CTRL_IRQ);
        apb_read(`RT_ADDR_SYSTIM, 32'h0, 32'hffff_ffff, base);
        apb_write(`RT_ADDR_ALARM_CMP, base + 5);
        apb_write(`RT_ADDR_CTRL, CTRL_TIMER | CTRL_ALARM | CTRL_IRQ);
        wait_for_irq();
        model_status = 1'b1;
        check_register(`RT_ADDR_STATUS);
        apb_write(`RT_ADDR_STATUS, 32'h1);
        repeat (100) begin
            @(posedge clk);
            #1;
            assert (irq == 1'b0)
                else begin
                    $display("[ERROR] irq = 0x%h, expected 0x0", irq);
                    error_count++;
                end
        end
        check_register(`RT_ADDR_STATUS);
        check_register(`RT_ADDR_ALARM_CMP);
        end_test("one-shot alarm");

        apb_write(`RT_ADDR_CTRL, CTRL_TIMER | CTRL_IRQ);
        apb_write(`RT_ADDR_PRESCALE, 32'd3);
        apb_write(`RT_ADDR_ALARM_PERIOD, 32'd10);
        apb_read(`RT_ADDR_SYSTIM, 32'h0, 32'hffff_ffff, base);
        apb_write(`RT_ADDR_ALARM_CMP, base + 8);
        apb_write(`RT_ADDR_CTRL, CTRL_TIMER | CTRL_ALARM | CTRL_PERIODIC | CTRL_IRQ);
        repeat (3) begin
            wait_for_irq();
            model_cmp    = model_cmp + model_period;
            model_status = 1'b1;
            check_register(`RT_ADDR_ALARM_CMP);
            check_register(`RT_ADDR_STATUS);
            apb_write(`RT_ADDR_STATUS, 32'h1);
        end
        // one more fire with the interrupt masked, which irq must not follow.
        apb_write(`RT_ADDR_CTRL, CTRL_TIMER | CTRL_ALARM | CTRL_PERIODIC);
        wait_for_pending();
        model_cmp    = model_cmp + model_period;
        model_status = 1'b1;
        apb_write(`RT_ADDR_CTRL, CTRL_TIMER);
        apb_write(`RT_ADDR_STATUS, 32'h1);
        end_test("periodic alarm");

        apb_read(8'h18, 32'h0, 32'h0, data);
        apb_write(8'h18, 32'hffff_ffff);
        check_register(`RT_ADDR_CTRL);
        check_register(`RT_ADDR_PRESCALE);
        check_register(`RT_ADDR_ALARM_CMP);
        check_register(`RT_ADDR_ALARM_PERIOD);
        check_register(`RT_ADDR_STATUS);
        end_test("bad address");

        $display("tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
        if (tests_failed == 0 && error_count == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sim.f
+incdir+common
common/rtos_timer_pkg.sv
timer/sys_timer.sv
timer/alarm_ctrl.sv
src/apb_timer_regs.sv
src/rtos_timer_top.sv
tb/tb_rtos_timer.sv

//--- Bender.yml
package:
  name: rtos_timer

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/rtos_timer_pkg.sv
      - timer/sys_timer.sv
      - timer/alarm_ctrl.sv
      - src/apb_timer_regs.sv
      - src/rtos_timer_top.sv

  - target: test
    include_dirs:
      - common
    files:
      - tb/tb_rtos_timer.sv
